// File: src/riscv_isa_pkg.sv
// ------------------------------------------------
// RV32 instruction encoding constants and the two
// views of a fetched word: the whole instruction
// and the fields of a cm.jt / cm.jalt half-word.
// Referenced by scoped names from the design.
// ------------------------------------------------

package riscv_isa_pkg;

  // Major opcode of jal
  localparam logic [6:0] opcode_jal = 7'b1101111;

  // Link register choices for the expanded jal
  localparam logic [4:0] reg_zero = 5'd0;
  localparam logic [4:0] reg_ra   = 5'd1;

  // Fixed field values of a table jump
  localparam logic [2:0] cmj_funct3     = 3'b101;
  localparam logic [2:0] cmj_funct3_sub = 3'b000;

  // Low half-word of cm.jt / cm.jalt
  typedef struct packed {
    logic [2:0] funct3;
    logic [2:0] funct3_sub;
    logic [7:0] index;
    logic [1:0] op;
  } cmj_fields_t;

  // Upper half is don't care for a 16-bit macro
  typedef struct packed {
    logic [15:0] unused;
    cmj_fields_t lower;
  } cmj_word_t;

  // Passed through as raw, expanded through cmj
  typedef union packed {
    logic [31:0] raw;
    cmj_word_t   cmj;
  } fetch_word_u;

endpackage

// File: src/zcmt_pkg.sv
// ------------------------------------------------
// Constants and types of the table-jump subsystem:
// JVT register layout, decoder states and the
// request/response structs of the table port.
// ------------------------------------------------

package zcmt_pkg;

  // Data and address width, RV32 only
  localparam int unsigned xlen = 32;

  // Indices from here upward are cm.jalt
  localparam logic [7:0] jalt_first_index = 8'd32;

  // Table entries are one word each
  localparam int unsigned entry_shift = 2;

  // Table base is 64-byte aligned
  localparam int unsigned jvt_base_lsb = 6;

  typedef enum logic [1:0] {
    idle,
    req,
    wait_rsp,
    jump
  } zcmt_state_e;

  // JVT CSR layout, base above the mode bits
  typedef struct packed {
    logic [xlen-jvt_base_lsb-1:0] base;
    logic [jvt_base_lsb-1:0]      mode;
  } jvt_t;

  // Single-word read request, valid is a one-cycle pulse
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] addr;
  } table_req_t;

  // Read response, valid is a one-cycle pulse
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] data;
  } table_rsp_t;

endpackage

// File: src/jvt_csr.sv
// ------------------------------------------------
// JVT register. Written by the CSR strobe, read
// back on jvt_rdata_o and fed to the decoder as
// table base and mode.
// ------------------------------------------------

`timescale 1ns/1ps

module jvt_csr (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      csr_we_i,
  input  logic [zcmt_pkg::xlen-1:0] csr_wdata_i,
  output zcmt_pkg::jvt_t            jvt_o,
  output logic [zcmt_pkg::xlen-1:0] jvt_rdata_o
);

  zcmt_pkg::jvt_t jvt_d;
  zcmt_pkg::jvt_t jvt_q;

  // Split the written word into base and mode
  always_comb begin
    jvt_d = jvt_q;
    if (csr_we_i) begin
      jvt_d.base = csr_wdata_i[zcmt_pkg::xlen-1:zcmt_pkg::jvt_base_lsb];
      // All mode bits are kept so an unsupported mode reads back
      jvt_d.mode = csr_wdata_i[zcmt_pkg::jvt_base_lsb-1:0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      jvt_q <= '0;
    end else begin
      jvt_q <= jvt_d;
    end
  end

  // Decoder sees the new value one cycle after the write
  assign jvt_o = jvt_q;

  // CSR read view
  assign jvt_rdata_o = {jvt_q.base, jvt_q.mode};

endmodule

// File: src/jal_encoder.sv
// ------------------------------------------------
// Builds the jal that replaces a table jump. The
// offset is target minus pc, checked against the
// +/- 1 MiB reach of the J-type immediate.
// ------------------------------------------------

`timescale 1ns/1ps

module jal_encoder (
  input  logic [zcmt_pkg::xlen-1:0] target_i,
  input  logic [zcmt_pkg::xlen-1:0] pc_i,
  input  logic                      link_i,
  output logic [31:0]               jal_o,
  output logic                      in_range_o
);

  logic [zcmt_pkg::xlen-1:0] target_aligned;
  logic [zcmt_pkg::xlen-1:0] offset;
  logic [20:0]               imm;
  logic [4:0]                rd;

  // Jump targets ignore bit 0
  assign target_aligned = {target_i[zcmt_pkg::xlen-1:1], 1'b0};

  assign offset = target_aligned - pc_i;

  // Fits when bits above 20 are copies of the sign bit
  assign in_range_o = (&offset[zcmt_pkg::xlen-1:20]) | ~(|offset[zcmt_pkg::xlen-1:20]);

  assign imm = offset[20:0];

  // cm.jalt links through ra
  assign rd = link_i ? riscv_isa_pkg::reg_ra : riscv_isa_pkg::reg_zero;

  // J-format scatter: imm[20|10:1|11|19:12]
  assign jal_o = {
    imm[20],
    imm[10:1],
    imm[11],
    imm[19:12],
    rd,
    riscv_isa_pkg::opcode_jal
  };

endmodule

// File: src/zcmt_decoder.sv
// ------------------------------------------------
// Expands cm.jt / cm.jalt into a single jal.
// A valid macro stalls fetch, reads one entry from
// the jump table and holds the jal until issue
// acknowledges it. Other words pass straight through.
// ------------------------------------------------

`timescale 1ns/1ps

module zcmt_decoder (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  riscv_isa_pkg::fetch_word_u instr_i,
  input  logic [zcmt_pkg::xlen-1:0]  pc_i,
  input  logic                       is_macro_instr_i,
  input  logic                       illegal_instr_i,
  input  logic                       is_compressed_i,
  input  logic                       issue_ack_i,
  input  zcmt_pkg::jvt_t             jvt_i,
  input  zcmt_pkg::table_rsp_t       table_rsp_i,
  output logic [31:0]                instr_o,
  output logic                       illegal_instr_o,
  output logic                       is_compressed_o,
  output logic                       fetch_stall_o,
  output logic                       is_last_macro_instr_o,
  output zcmt_pkg::table_req_t       table_req_o
);

  riscv_isa_pkg::cmj_fields_t fields;
  logic                       fields_ok;
  logic                       mode_ok;
  logic                       start_macro;
  logic                       link_d;
  logic [zcmt_pkg::xlen-1:0]  table_base;
  logic [zcmt_pkg::xlen-1:0]  table_offset;
  logic [zcmt_pkg::xlen-1:0]  table_addr;

  zcmt_pkg::zcmt_state_e state_d;
  zcmt_pkg::zcmt_state_e state_q;

  logic [31:0]               macro_q;
  logic [zcmt_pkg::xlen-1:0] pc_q;
  logic [zcmt_pkg::xlen-1:0] addr_q;
  logic [zcmt_pkg::xlen-1:0] entry_q;
  logic                      link_q;

  logic [31:0] jal_word;
  logic        jal_in_range;

  // Macro view of the fetched word
  assign fields = instr_i.cmj.lower;

  assign fields_ok = (fields.funct3 == riscv_isa_pkg::cmj_funct3) &&
                     (fields.funct3_sub == riscv_isa_pkg::cmj_funct3_sub);

  // Only jump table mode 0 is supported
  assign mode_ok = (jvt_i.mode == '0);

  assign start_macro = (state_q == zcmt_pkg::idle) && is_macro_instr_i &&
                       fields_ok && mode_ok;

  assign link_d = (fields.index >= zcmt_pkg::jalt_first_index);

  // Entry address is base + index * entry size
  assign table_base   = {jvt_i.base, {zcmt_pkg::jvt_base_lsb{1'b0}}};
  assign table_offset = {{(zcmt_pkg::xlen-8){1'b0}}, fields.index} << zcmt_pkg::entry_shift;
  assign table_addr   = table_base + table_offset;

  jal_encoder i_jal_encoder (
    .target_i   (entry_q),
    .pc_i       (pc_q),
    .link_i     (link_q),
    .jal_o      (jal_word),
    .in_range_o (jal_in_range)
  );

  // Next state and outputs
  always_comb begin
    state_d               = state_q;
    instr_o               = macro_q;
    illegal_instr_o       = 1'b0;
    fetch_stall_o         = 1'b1;
    is_last_macro_instr_o = 1'b0;

    case (state_q)
      zcmt_pkg::idle: begin
        instr_o       = instr_i.raw;
        fetch_stall_o = start_macro;
        if (is_macro_instr_i) begin
          // Rejected macros go to issue as illegal
          illegal_instr_o = ~(fields_ok && mode_ok);
        end else begin
          illegal_instr_o = illegal_instr_i;
        end
        if (start_macro) begin
          state_d = zcmt_pkg::req;
        end
      end
      zcmt_pkg::req: begin
        state_d = zcmt_pkg::wait_rsp;
      end
      zcmt_pkg::wait_rsp: begin
        if (table_rsp_i.valid) begin
          state_d = zcmt_pkg::jump;
        end
      end
      zcmt_pkg::jump: begin
        is_last_macro_instr_o = 1'b1;
        if (jal_in_range) begin
          instr_o = jal_word;
        end else begin
          illegal_instr_o = 1'b1;
        end
        // Stall drops in the ack cycle
        if (issue_ack_i) begin
          fetch_stall_o = 1'b0;
          state_d       = zcmt_pkg::idle;
        end
      end
      default: begin
        state_d = zcmt_pkg::idle;
      end
    endcase
  end

  assign is_compressed_o = (state_q != zcmt_pkg::idle) || is_macro_instr_i || is_compressed_i;

  // One-cycle read strobe
  assign table_req_o.valid = (state_q == zcmt_pkg::req);
  assign table_req_o.addr  = addr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= zcmt_pkg::idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Macro context captured at start, entry captured on response
  always_ff @(posedge clk_i) begin
    if (start_macro) begin
      macro_q <= instr_i.raw;
      pc_q    <= pc_i;
      addr_q  <= table_addr;
      link_q  <= link_d;
    end
    if ((state_q == zcmt_pkg::wait_rsp) && table_rsp_i.valid) begin
      entry_q <= table_rsp_i.data;
    end
  end

endmodule

// File: src/zcmt_top.sv
// ------------------------------------------------
// Table-jump block for the fetch path. Connects the
// JVT register to the macro decoder and exposes the
// fetch, issue, CSR and jump-table ports.
// ------------------------------------------------

`timescale 1ns/1ps

module zcmt_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       csr_we_i,
  input  logic [zcmt_pkg::xlen-1:0]  csr_wdata_i,
  output logic [zcmt_pkg::xlen-1:0]  jvt_rdata_o,
  input  riscv_isa_pkg::fetch_word_u instr_i,
  input  logic [zcmt_pkg::xlen-1:0]  pc_i,
  input  logic                       is_macro_instr_i,
  input  logic                       is_compressed_i,
  input  logic                       illegal_instr_i,
  input  logic                       issue_ack_i,
  output logic [31:0]                instr_o,
  output logic                       illegal_instr_o,
  output logic                       is_compressed_o,
  output logic                       fetch_stall_o,
  output logic                       is_last_macro_instr_o,
  output zcmt_pkg::table_req_t       table_req_o,
  input  zcmt_pkg::table_rsp_t       table_rsp_i
);

  zcmt_pkg::jvt_t jvt;

  jvt_csr i_jvt_csr (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .csr_we_i    (csr_we_i),
    .csr_wdata_i (csr_wdata_i),
    .jvt_o       (jvt),
    .jvt_rdata_o (jvt_rdata_o)
  );

  zcmt_decoder i_decoder (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .instr_i               (instr_i),
    .pc_i                  (pc_i),
    .is_macro_instr_i      (is_macro_instr_i),
    .illegal_instr_i       (illegal_instr_i),
    .is_compressed_i       (is_compressed_i),
    .issue_ack_i           (issue_ack_i),
    .jvt_i                 (jvt),
    .table_rsp_i           (table_rsp_i),
    .instr_o               (instr_o),
    .illegal_instr_o       (illegal_instr_o),
    .is_compressed_o       (is_compressed_o),
    .fetch_stall_o         (fetch_stall_o),
    .is_last_macro_instr_o (is_last_macro_instr_o),
    .table_req_o           (table_req_o)
  );

endmodule

// File: tests/zcmt_table_model.sv
// ------------------------------------------------
// Jump-table memory model for the testbench. Each
// read request is answered with one response pulse
// after latency_i cycles (at least one), carrying
// the entry word given on entry_i.
// ------------------------------------------------

`timescale 1ns/1ps

module zcmt_table_model (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  zcmt_pkg::table_req_t table_req_i,
  input  logic [3:0]           latency_i,
  input  logic [31:0]          entry_i,
  output zcmt_pkg::table_rsp_t table_rsp_o
);

  // Cycles left until the response pulse
  logic [3:0] remaining_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      remaining_q <= 4'd0;
      table_rsp_o <= '0;
    end else begin
      table_rsp_o.valid <= 1'b0;
      if (table_req_i.valid) begin
        if (latency_i > 4'd1) begin
          remaining_q <= latency_i - 4'd1;
        end else begin
          // Answer in the cycle right after the request
          table_rsp_o <= {1'b1, entry_i};
        end
      end else if (remaining_q != 4'd0) begin
        remaining_q <= remaining_q - 4'd1;
        if (remaining_q == 4'd1) begin
          table_rsp_o <= {1'b1, entry_i};
        end
      end
    end
  end

endmodule

// File: tests/tb_zcmt.sv
// ------------------------------------------------
// Testbench for the table-jump block. A table of
// rows is applied in a loop: pass-through words,
// cm.jt / cm.jalt expansions and rejected macros.
// The jump table is answered by a memory model.
// ------------------------------------------------

`timescale 1ns/1ps

module tb_zcmt;

  typedef struct packed {
    logic [31:0] jvt;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        macro;
    logic        illegal_in;
    logic        compressed;
    logic [31:0] entry;
    logic [3:0]  latency;
    logic        exp_req;
    logic [31:0] exp_addr;
    logic [31:0] exp_instr;
    logic        exp_illegal;
    logic        exp_compressed;
  } test_row_t;

  localparam int timeout_cycles = 20;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       csr_we_i;
  logic [31:0]                csr_wdata_i;
  logic [31:0]                jvt_rdata_o;
  riscv_isa_pkg::fetch_word_u instr_i;
  logic [31:0]                pc_i;
  logic                       is_macro_instr_i;
  logic                       is_compressed_i;
  logic                       illegal_instr_i;
  logic                       issue_ack_i;
  logic [31:0]                instr_o;
  logic                       illegal_instr_o;
  logic                       is_compressed_o;
  logic                       fetch_stall_o;
  logic                       is_last_macro_instr_o;
  zcmt_pkg::table_req_t       table_req_o;
  zcmt_pkg::table_rsp_t       table_rsp_i;
  logic [3:0]                 cur_latency;
  logic [31:0]                cur_entry;
  integer                     seed;
  test_row_t                  rows[$];
  string                      names[$];

  zcmt_top i_dut (.*);

  zcmt_table_model i_table (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .table_req_i (table_req_o),
    .latency_i   (cur_latency),
    .entry_i     (cur_entry),
    .table_rsp_o (table_rsp_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_req(input string name, input zcmt_pkg::table_req_t exp,
                           input zcmt_pkg::table_req_t act);
    if (act !== exp) fail_now($sformatf("MISMATCH %s table_req exp=%h act=%h", name, exp, act));
  endtask

  task automatic check_instr(input string name, input logic [31:0] exp_instr, input logic exp_ill,
                             input logic [31:0] act_instr, input logic act_ill);
    if (act_instr !== exp_instr || act_ill !== exp_ill) begin
      fail_now($sformatf("MISMATCH %s instr/illegal exp=%h/%b act=%h/%b",
                         name, exp_instr, exp_ill, act_instr, act_ill));
    end
  endtask

  task automatic check_jvt(input string name, input zcmt_pkg::jvt_t exp, input zcmt_pkg::jvt_t act);
    if (act !== exp) fail_now($sformatf("MISMATCH %s jvt exp=%h act=%h", name, exp, act));
  endtask

  task automatic check_flag(input string name, input string what, input logic exp, input logic act);
    if (act !== exp) fail_now($sformatf("MISMATCH %s %s exp=%b act=%b", name, what, exp, act));
  endtask

  // 16-bit macro in the C2 quadrant, upper half zero
  function automatic logic [31:0] cmj_word(logic [2:0] f3, logic [2:0] f3s, logic [7:0] index);
    riscv_isa_pkg::fetch_word_u w;
    w.raw = 32'h0;
    w.cmj.lower.funct3 = f3;
    w.cmj.lower.funct3_sub = f3s;
    w.cmj.lower.index = index;
    w.cmj.lower.op = 2'b10;
    return w.raw;
  endfunction

  task automatic add_plain(input string name, input logic [31:0] word, input logic ill,
                           input logic comp);
    test_row_t r;
    r = '0;
    r.instr = word;
    r.illegal_in = ill;
    r.compressed = comp;
    r.latency = 4'd1;
    r.exp_instr = word;
    r.exp_illegal = ill;
    r.exp_compressed = comp;
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic add_macro(input string name, input logic [31:0] jvt, input logic [2:0] f3,
                           input logic [2:0] f3s, input logic [7:0] index, input logic [31:0] pc,
                           input logic [31:0] entry, input logic [3:0] latency);
    test_row_t r;
    logic signed [31:0] off;
    r = '0;
    r.jvt = jvt;
    r.instr = cmj_word(f3, f3s, index);
    r.pc = pc;
    r.macro = 1'b1;
    r.entry = entry;
    r.latency = latency;
    r.exp_addr = {jvt[31:6], 6'b0} + {22'b0, index, 2'b00};
    r.exp_req = (f3 == 3'b101) && (f3s == 3'b000) && (jvt[5:0] == 6'd0);
    r.exp_instr = r.instr;
    r.exp_illegal = 1'b1;
    // A macro is a 16-bit instruction
    r.exp_compressed = 1'b1;
    off = {entry[31:1], 1'b0} - pc;
    // jal reaches -1 MiB up to just below +1 MiB
    if (r.exp_req && off >= -32'sd1048576 && off < 32'sd1048576) begin
      r.exp_illegal = 1'b0;
      r.exp_instr = {off[20], off[10:1], off[11], off[19:12],
                     (index >= 8'd32) ? 5'd1 : 5'd0, riscv_isa_pkg::opcode_jal};
    end
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic build_table();
    add_plain("pass_a", $random(seed), 1'b0, 1'b1);
    add_plain("pass_b", $random(seed), 1'b1, 1'b0);
    add_macro("jt_idx0", 32'h0001_0000, 3'b101, 3'b000, 8'd0, 32'h0001_2000, 32'h0001_4001, 4'd1);
    add_macro("jt_back", 32'h0002_0040, 3'b101, 3'b000, 8'd5, 32'h0002_0100, 32'h0001_f000, 4'd3);
    add_macro("jalt_32", 32'h8000_0000, 3'b101, 3'b000, 8'd32, 32'h8000_1000, 32'h8000_0800, 4'd2);
    add_macro("jalt_255", 32'h0004_0000, 3'b101, 3'b000, 8'd255, 32'h0004_0200, 32'h0005_8124,
              4'd5);
    add_macro("rej_mode", 32'h0001_0001, 3'b101, 3'b000, 8'd3, 32'h0001_0000, 32'h0001_0100, 4'd1);
    add_macro("rej_f3", 32'h0001_0000, 3'b100, 3'b000, 8'd3, 32'h0001_0000, 32'h0001_0100, 4'd1);
    add_macro("rej_sub", 32'h0001_0000, 3'b101, 3'b001, 8'd3, 32'h0001_0000, 32'h0001_0100, 4'd1);
    add_macro("jt_far", 32'h0001_0000, 3'b101, 3'b000, 8'd7, 32'h0001_0000, 32'h0011_0000, 4'd4);
    add_macro("jalt_edge", 32'h0001_0000, 3'b101, 3'b000, 8'd40, 32'h0011_0000, 32'h0001_0000,
              4'd1);
  endtask

  task automatic run_row(input int i);
    test_row_t r;
    int        delay;
    int        cycles;
    r = rows[i];
    cur_latency = r.latency;
    cur_entry = r.entry;
    @(negedge clk_i);
    csr_we_i = 1'b1;
    csr_wdata_i = r.jvt;
    @(negedge clk_i);
    csr_we_i = 1'b0;
    instr_i.raw = r.instr;
    pc_i = r.pc;
    is_macro_instr_i = r.macro;
    illegal_instr_i = r.illegal_in;
    is_compressed_i = r.compressed;
    #1;
    check_jvt(names[i], r.jvt, jvt_rdata_o);
    check_flag(names[i], "fetch_stall_o", r.exp_req, fetch_stall_o);
    if (!r.exp_req) begin
      // Combinational result, and no table read may follow
      repeat (4) begin
        check_instr(names[i], r.exp_instr, r.exp_illegal, instr_o, illegal_instr_o);
        check_flag(names[i], "table_req_o.valid", 1'b0, table_req_o.valid);
        check_flag(names[i], "is_compressed_o", r.exp_compressed, is_compressed_o);
        @(negedge clk_i);
        #1;
      end
    end else begin
      cycles = 0;
      while (table_req_o.valid !== 1'b1) begin
        if (cycles == timeout_cycles) fail_now({names[i], ": no table request was issued"});
        @(negedge clk_i);
        #1;
        cycles++;
      end
      check_req(names[i], {1'b1, r.exp_addr}, table_req_o);
      @(negedge clk_i);
      #1;
      check_flag(names[i], "table_req_o.valid", 1'b0, table_req_o.valid);
      cycles = 0;
      while (is_last_macro_instr_o !== 1'b1) begin
        if (cycles == timeout_cycles) fail_now({names[i], ": expanded jal never appeared"});
        @(negedge clk_i);
        #1;
        cycles++;
      end
      // Outputs hold while issue is back-pressured
      delay = $unsigned($random(seed)) % 4;
      repeat (delay) begin
        check_instr(names[i], r.exp_instr, r.exp_illegal, instr_o, illegal_instr_o);
        check_flag(names[i], "fetch_stall_o", 1'b1, fetch_stall_o);
        check_flag(names[i], "is_compressed_o", 1'b1, is_compressed_o);
        @(negedge clk_i);
        #1;
      end
      @(negedge clk_i);
      issue_ack_i = 1'b1;
      #1;
      check_instr(names[i], r.exp_instr, r.exp_illegal, instr_o, illegal_instr_o);
      check_flag(names[i], "is_last_macro_instr_o", 1'b1, is_last_macro_instr_o);
      check_flag(names[i], "fetch_stall_o", 1'b0, fetch_stall_o);
      check_flag(names[i], "is_compressed_o", r.exp_compressed, is_compressed_o);
    end
    @(negedge clk_i);
    issue_ack_i = 1'b0;
    is_macro_instr_i = 1'b0;
    illegal_instr_i = 1'b0;
    is_compressed_i = 1'b0;
    instr_i.raw = 32'h0;
    #1;
    check_flag(names[i], "is_last_macro_instr_o", 1'b0, is_last_macro_instr_o);
    check_flag(names[i], "fetch_stall_o", 1'b0, fetch_stall_o);
  endtask

  initial begin
    seed = 32'hb7ed;
    rst_ni = 1'b0;
    csr_we_i = 1'b0;
    csr_wdata_i = 32'h0;
    instr_i.raw = 32'h0;
    pc_i = 32'h0;
    is_macro_instr_i = 1'b0;
    is_compressed_i = 1'b0;
    illegal_instr_i = 1'b0;
    issue_ack_i = 1'b0;
    cur_latency = 4'd1;
    cur_entry = 32'h0;
    build_table();
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    check_jvt("reset", '0, jvt_rdata_o);
    check_flag("reset", "fetch_stall_o", 1'b0, fetch_stall_o);
    check_flag("reset", "is_last_macro_instr_o", 1'b0, is_last_macro_instr_o);
    check_flag("reset", "table_req_o.valid", 1'b0, table_req_o.valid);
    foreach (rows[i]) begin
      run_row(i);
    end
    $display("All tests passed");
    $finish;
  end

endmodule

// File: tb.f
src/riscv_isa_pkg.sv
src/zcmt_pkg.sv
src/jvt_csr.sv
src/jal_encoder.sv
src/zcmt_decoder.sv
src/zcmt_top.sv
tests/zcmt_table_model.sv
tests/tb_zcmt.sv

// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_zcmt
FILE_LIST = tb.f
PASS_MSG  = All tests passed

.PHONY: simulate clean

# Build and run; the status comes from searching the output for the pass line
simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
